/* build.f */
hw/clock_pkg.sv
hw/set_if.sv
hw/timebase.sv
hw/button_sync.sv
hw/mode_ctrl.sv
hw/hms_counter.sv
hw/time_keeper.sv
hw/seg_encoder.sv
hw/display_scan.sv
hw/alarm_tone.sv
hw/clock_top.sv
dv/tb_clock.sv

/* dv/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock;

	localparam int CLK_HZ   = 2000;
	localparam int SEC_CYC  = CLK_HZ;
	localparam int PRESS_CYC = 420;	// worst case incl. wait for a quiet window
	localparam int T_RESET  = 200;
	localparam int T_TIME   = 64 * (2048 + SEC_CYC + 20);
	localparam int T_SET    = 3 * (11 * PRESS_CYC + 450) + 2 * PRESS_CYC;
	localparam int T_ALARM  = 3 * (11 * PRESS_CYC + 450) + PRESS_CYC;
	localparam int T_SOUND  = 150 * PRESS_CYC + 6 * SEC_CYC + 16000 + PRESS_CYC;
	localparam int WD_CYC   = (T_RESET + T_TIME + T_SET + T_ALARM + T_SOUND) * 12 / 10;

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;
	logic [6:0] o_seg;
	logic [5:0] o_seg_enb;
	logic       o_buzz;

	// model state
	int m_mode, m_pos, m_en, m_alarm;
	int m_sec, m_min, m_hr;
	int a_sec, a_min, a_hr;
	int cyc;
	int blanks;
	int shown;
	logic [31:0] lfsr;
	logic [6:0]  frame [6];

	clock_top #(.p_clk_hz(CLK_HZ)) i_clock_top (
		.clk(clk), .rst_n(rst_n), .i_btn_mode(btn[0]), .i_btn_pos(btn[1]),
		.i_btn_inc(btn[2]), .i_btn_alarm(btn[3]), .o_seg(o_seg), .o_seg_enb(o_seg_enb),
		.o_buzz(o_buzz)
	);

	always #20 clk = ~clk;

	// --------------------
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};	// taps 32 22 2 1
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic logic [6:0] seg_of(input int d);
		case (d)
			0: return 7'b1111110;
			1: return 7'b0110000;
			2: return 7'b1101101;
			3: return 7'b1111001;
			4: return 7'b0110011;
			5: return 7'b1011011;
			6: return 7'b1011111;
			7: return 7'b1110000;
			8: return 7'b1111111;
			default: return 7'b1111011;
		endcase
	endfunction

	// active low enable with only one digit lit
	function automatic logic [5:0] enb_for(input int idx);
		logic [5:0] e;
		e = '1;
		e[idx] = 1'b0;
		return e;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s at %0t", what, $time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// --------------------
	// time model, sec strobe lands on cycle 1 mod 2000 after release
	always @(posedge clk) begin
		if (rst_n) begin
			cyc++;
			if (cyc > 1 && cyc % SEC_CYC == 1) begin
				if (m_en && m_sec == a_sec && m_min == a_min && m_hr == a_hr)
					m_alarm = 1;
				if (m_mode != 1) begin
					m_sec = (m_sec + 1) % 60;
					if (m_sec == 0) begin
						m_min = (m_min + 1) % 60;
						if (m_min == 0)
							m_hr = (m_hr + 1) % 24;
					end
				end
			end
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	// keeps a whole press clear of a sec strobe
	task automatic press(input int b);
		step_cycle();
		while (cyc % SEC_CYC < 100 || cyc % SEC_CYC > 1800)
			step_cycle();
		btn[b] = 1'b1;
		repeat (60) step_cycle();
		btn[b] = 1'b0;
		repeat (60) step_cycle();
		case (b)
			0: m_mode = (m_mode + 1) % 3;
			1: m_pos = (m_pos + 1) % 3;
			3: begin
				m_en = !m_en;
				if (!m_en)
					m_alarm = 0;
			end
			default: begin
				if (m_mode == 1) begin
					case (m_pos)
						0: m_sec = (m_sec + 1) % 60;
						1: m_min = (m_min + 1) % 60;
						default: m_hr = (m_hr + 1) % 24;
					endcase
				end else if (m_mode == 2) begin
					case (m_pos)
						0: a_sec = (a_sec + 1) % 60;
						1: a_min = (a_min + 1) % 60;
						default: a_hr = (a_hr + 1) % 24;
					endcase
				end
			end
		endcase
	endtask

	task automatic goto_mode(input int m);
		while (m_mode != m)
			press(0);
	endtask

	task automatic goto_pos(input int p);
		while (m_pos != p)
			press(1);
	endtask

	// one full scan, compared digit by digit
	task automatic check_frame();
		int seen;
		int idx;
		int v;
		int sel;
		logic [6:0] exp;
		while (cyc % SEC_CYC < 6 || cyc % SEC_CYC > 1980)
			step_cycle();
		seen = 0;
		while (seen != 6'h3f) begin
			@(negedge clk);
			idx = 0;
			for (int i = 0; i < 6; i++) begin
				if (!o_seg_enb[i])
					idx = i;
			end
			check("o_seg_enb", o_seg_enb, enb_for(idx));
			frame[idx] = o_seg;
			seen |= 1 << idx;
		end
		for (int d = 0; d < 6; d++) begin
			if (m_mode == 2)
				v = (d < 2) ? a_sec : (d < 4) ? a_min : a_hr;
			else
				v = (d < 2) ? m_sec : (d < 4) ? m_min : m_hr;
			exp = (d % 2 == 0) ? seg_of(v % 10) : seg_of(v / 10);
			sel = (m_mode != 0) && (m_pos == d / 2);
			if (sel && frame[d] == 7'h00) begin
				blanks++;	// blink off phase
			end else begin
				if (sel)
					shown++;
				check($sformatf("o_seg digit %0d", d), frame[d], exp);
			end
		end
	endtask

	initial begin
		#(longint'(WD_CYC) * 40);
		abort_run("watchdog timeout, the run took too long");
	end

	initial begin
		int n;
		int start;
		int tgt;
		int prev;
		int steps;
		clk = 0;
		rst_n = 0;
		btn = '0;
		lfsr = 32'ha841;
		{m_mode, m_pos, m_en, m_alarm, cyc, blanks, shown} = '0;
		{m_sec, m_min, m_hr, a_sec, a_min, a_hr} = '0;
		repeat (5) @(posedge clk);
		#2 rst_n = 1;

		// --------------------
		// reset state and scan order
		@(negedge clk);
		check("o_seg_enb", o_seg_enb, 6'b111110);
		check("o_buzz", o_buzz, 0);
		prev = 0;
		steps = 0;
		repeat (40) begin
			@(negedge clk);
			if (o_seg_enb != enb_for(prev)) begin
				prev = (prev + 1) % 6;
				steps++;
				check("o_seg_enb", o_seg_enb, enb_for(prev));
			end
		end
		if (steps < 6)
			abort_run("digit enable did not step through all six digits");
		check_frame();

		// timekeeping across a minute carry
		repeat (64) begin
			repeat (SEC_CYC + rand_bits(11)) step_cycle();
			check_frame();
		end

		// --------------------
		// set mode, one field at a time
		goto_mode(1);
		for (int p = 0; p < 3; p++) begin
			goto_pos(p);
			n = 1 + rand_bits(3);
			repeat (n) press(2);
			blanks = 0;
			shown = 0;
			start = cyc;
			while (cyc - start < 400)
				check_frame();
			if (blanks == 0)
				abort_run("selected field never blanked in set mode");
			if (shown == 0)
				abort_run("selected field never shown in set mode");
		end

		// alarm fields
		goto_mode(2);
		for (int p = 0; p < 3; p++) begin
			goto_pos(p);
			n = 1 + rand_bits(3);
			repeat (n) press(2);
			start = cyc;
			while (cyc - start < 400)
				check_frame();
		end

		// --------------------
		// time four seconds before the alarm, then let it run
		goto_mode(1);
		tgt = (a_hr * 3600 + a_min * 60 + a_sec + 86400 - 4) % 86400;
		goto_pos(2);
		repeat ((tgt / 3600 - m_hr + 24) % 24) press(2);
		goto_pos(1);
		repeat ((tgt / 60 % 60 - m_min + 60) % 60) press(2);
		goto_pos(0);
		repeat ((tgt % 60 - m_sec + 60) % 60) press(2);
		press(3);
		press(0);
		start = cyc;
		while (!m_alarm) begin
			@(negedge clk);
			check("o_buzz", o_buzz, 0);
			if (cyc - start > 6 * SEC_CYC)
				abort_run("alarm time never reached in the model");
		end
		start = cyc;
		while (o_buzz !== 1'b1) begin
			@(negedge clk);
			if (cyc - start > 8 * 1000)
				abort_run("buzzer did not sound after the alarm match");
		end
		press(3);
		repeat (8 * 1000) begin
			@(negedge clk);
			check("o_buzz", o_buzz, 0);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* hw/clock_top.sv */
`timescale 1ns/10ps

module clock_top
	import clock_pkg::*;
#(
	parameter int p_clk_hz = 50_000_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output logic [SEG_W-1:0]      o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_buzz
);

	logic               sec_tick;
	logic               sample_tick;
	logic               scan_tick;
	logic               beat_tick;
	logic               blink_on;
	logic [3:0]         btn;
	logic [3:0]         press;
	logic [FIELD_W-1:0] show_sec;
	logic [FIELD_W-1:0] show_min;
	logic [FIELD_W-1:0] show_hr;
	logic               alarm_active;
	logic [SEG_W-1:0]   digit_seg [NUM_DIGITS];

	assign btn[BTN_MODE]  = i_btn_mode;
	assign btn[BTN_POS]   = i_btn_pos;
	assign btn[BTN_INC]   = i_btn_inc;
	assign btn[BTN_ALARM] = i_btn_alarm;

	set_if u_set_if ();

	timebase #(.p_clk_hz(p_clk_hz)) u_timebase (
		.clk(clk), .rst_n(rst_n), .o_sec_tick(sec_tick), .o_sample_tick(sample_tick),
		.o_scan_tick(scan_tick), .o_beat_tick(beat_tick), .o_blink_on(blink_on)
	);

	button_sync u_button_sync (
		.clk(clk), .rst_n(rst_n), .i_sample_tick(sample_tick), .i_btn(btn), .o_press(press)
	);

	mode_ctrl u_mode_ctrl (.clk(clk), .rst_n(rst_n), .i_press(press), .sif(u_set_if));

	time_keeper u_time_keeper (
		.clk(clk), .rst_n(rst_n), .i_sec_tick(sec_tick), .sif(u_set_if),
		.o_sec(show_sec), .o_min(show_min), .o_hr(show_hr), .o_alarm_active(alarm_active)
	);

	seg_encoder u_seg_encoder (
		.i_sec(show_sec), .i_min(show_min), .i_hr(show_hr), .i_blink_on(blink_on),
		.sif(u_set_if), .o_digit_seg(digit_seg)
	);

	display_scan u_display_scan (
		.clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick), .i_digit_seg(digit_seg),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb)
	);

	alarm_tone #(.p_clk_hz(p_clk_hz)) u_alarm_tone (
		.clk(clk), .rst_n(rst_n), .i_beat_tick(beat_tick),
		.i_alarm_active(alarm_active), .o_buzz(o_buzz)
	);

endmodule

/* hw/alarm_tone.sv */
`timescale 1ns/10ps

module alarm_tone
	import clock_pkg::*;
#(
	parameter int p_clk_hz = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_beat_tick,
	input  logic i_alarm_active,
	output logic o_buzz
);

	localparam int STEP_W = $clog2(MELODY_LEN);
	localparam int HALF_W = $clog2(p_clk_hz + 1);

	// clk cycles per half period of a note, 0 for a rest
	function automatic int half_of(input int hz);
		if (hz == 0) begin
			return 0;
		end else begin
			return (p_clk_hz / (2 * hz) > 0) ? p_clk_hz / (2 * hz) : 1;
		end
	endfunction

	logic [HALF_W-1:0] half_tbl [MELODY_LEN];
	logic [STEP_W-1:0] step;
	logic [HALF_W-1:0] half_cnt;
	logic [HALF_W-1:0] note_half;
	logic              rest;
	logic              buzz_q;

	for (genvar n = 0; n < MELODY_LEN; n++) begin : g_note
		assign half_tbl[n] = HALF_W'(half_of(NOTE_HZ[n]));
	end

	assign note_half = half_tbl[step];
	assign rest      = (note_half == '0);

	// --------------------
	// melody position, restarts each time the alarm goes off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (!i_alarm_active) begin
			step <= '0;
		end else if (i_beat_tick) begin
			step <= (step == STEP_W'(MELODY_LEN - 1)) ? '0 : step + 1'b1;
		end
	end

	// square wave for the current note
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			half_cnt <= '0;
			buzz_q   <= 1'b0;
		end else if (!i_alarm_active || rest) begin
			half_cnt <= '0;
			buzz_q   <= 1'b0;
		end else if (half_cnt >= note_half - 1'b1) begin
			half_cnt <= '0;
			buzz_q   <= ~buzz_q;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	assign o_buzz = buzz_q && i_alarm_active && !rest;

endmodule

/* hw/display_scan.sv */
`timescale 1ns/10ps

module display_scan
	import clock_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  logic [SEG_W-1:0]      i_digit_seg [NUM_DIGITS],
	output logic [SEG_W-1:0]      o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [IDX_W-1:0] idx;	// digit being lit

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			idx <= (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
		end
	end

	// common node is active low
	assign o_seg_enb = ~(NUM_DIGITS'(1) << idx);
	assign o_seg     = i_digit_seg[idx];

endmodule

/* hw/seg_encoder.sv */
`timescale 1ns/10ps

module seg_encoder
	import clock_pkg::*;
(
	input  logic [FIELD_W-1:0] i_sec,
	input  logic [FIELD_W-1:0] i_min,
	input  logic [FIELD_W-1:0] i_hr,
	input  logic               i_blink_on,
	set_if.disp                sif,
	output logic [SEG_W-1:0]   o_digit_seg [NUM_DIGITS]
);

	localparam logic [1:0] FIELD_POS [3] = '{POS_SEC, POS_MIN, POS_HR};

	logic [FIELD_W-1:0] field [3];
	logic               editing;

	assign field[0] = i_sec;
	assign field[1] = i_min;
	assign field[2] = i_hr;

	assign editing = (sif.mode != MODE_CLOCK);	// set or alarm

	// two digits per field, ones on the lower index
	for (genvar f = 0; f < 3; f++) begin : g_field
		logic [3:0] tens;
		logic [3:0] ones;
		logic       blank;

		assign tens  = 4'(field[f] / 10);
		assign ones  = 4'(field[f] % 10);
		assign blank = editing && (sif.pos == FIELD_POS[f]) && !i_blink_on;

		assign o_digit_seg[2*f]   = blank ? SEG_BLANK : SEG_DIGIT[ones];
		assign o_digit_seg[2*f+1] = blank ? SEG_BLANK : SEG_DIGIT[tens];
	end

endmodule

/* hw/time_keeper.sv */
`timescale 1ns/10ps

module time_keeper
	import clock_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_sec_tick,
	set_if.keeper              sif,
	output logic [FIELD_W-1:0] o_sec,
	output logic [FIELD_W-1:0] o_min,
	output logic [FIELD_W-1:0] o_hr,
	output logic               o_alarm_active
);

	logic               run;
	logic               sec_wrap;
	logic               min_wrap;
	logic [FIELD_W-1:0] sec;
	logic [FIELD_W-1:0] min;
	logic [FIELD_W-1:0] hr;
	logic [FIELD_W-1:0] a_sec;
	logic [FIELD_W-1:0] a_min;
	logic [FIELD_W-1:0] a_hr;
	logic               match;
	logic               alarm_q;

	// time stands still while being set
	assign run = i_sec_tick && (sif.mode != MODE_SET);

	// --------------------
	// time of day, carries only when running
	hms_counter #(.p_max(SEC_MAX)) u_sec (
		.clk(clk), .rst_n(rst_n), .i_inc(run | sif.adv_sec), .o_count(sec), .o_wrap(sec_wrap)
	);
	hms_counter #(.p_max(MIN_MAX)) u_min (
		.clk(clk), .rst_n(rst_n), .i_inc((run & sec_wrap) | sif.adv_min),
		.o_count(min), .o_wrap(min_wrap)
	);
	hms_counter #(.p_max(HR_MAX)) u_hr (
		.clk(clk), .rst_n(rst_n), .i_inc((run & min_wrap) | sif.adv_hr),
		.o_count(hr), .o_wrap()
	);

	// --------------------
	// alarm time, one field per press
	hms_counter #(.p_max(SEC_MAX)) u_a_sec (
		.clk(clk), .rst_n(rst_n), .i_inc(sif.adv_alarm && (sif.pos == POS_SEC)),
		.o_count(a_sec), .o_wrap()
	);
	hms_counter #(.p_max(MIN_MAX)) u_a_min (
		.clk(clk), .rst_n(rst_n), .i_inc(sif.adv_alarm && (sif.pos == POS_MIN)),
		.o_count(a_min), .o_wrap()
	);
	hms_counter #(.p_max(HR_MAX)) u_a_hr (
		.clk(clk), .rst_n(rst_n), .i_inc(sif.adv_alarm && (sif.pos == POS_HR)),
		.o_count(a_hr), .o_wrap()
	);

	assign match = (sec == a_sec) && (min == a_min) && (hr == a_hr);

	// rings until the alarm is switched off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else if (!sif.alarm_en) begin
			alarm_q <= 1'b0;
		end else if (i_sec_tick && match) begin
			alarm_q <= 1'b1;
		end
	end

	assign o_sec          = (sif.mode == MODE_ALARM) ? a_sec : sec;
	assign o_min          = (sif.mode == MODE_ALARM) ? a_min : min;
	assign o_hr           = (sif.mode == MODE_ALARM) ? a_hr : hr;
	assign o_alarm_active = alarm_q;

endmodule

/* hw/hms_counter.sv */
`timescale 1ns/10ps

module hms_counter
	import clock_pkg::*;
#(
	parameter int p_max = SEC_MAX
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_inc,
	output logic [FIELD_W-1:0] o_count,
	output logic               o_wrap
);

	assign o_wrap = i_inc && (o_count == FIELD_W'(p_max));	// carry out

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (o_wrap) begin
			o_count <= '0;
		end else if (i_inc) begin
			o_count <= o_count + 1'b1;
		end
	end

endmodule

/* hw/mode_ctrl.sv */
`timescale 1ns/10ps

module mode_ctrl
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] i_press,
	set_if.ctrl        sif
);

	logic [1:0] mode_q;
	logic [1:0] pos_q;
	logic       alarm_en_q;
	logic       inc;
	logic       in_set;

	// --------------------
	// mode, position, alarm enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			alarm_en_q <= 1'b0;
		end else begin
			if (i_press[BTN_MODE]) begin
				mode_q <= (mode_q == MODE_ALARM) ? MODE_CLOCK : mode_q + 2'd1;
			end
			if (i_press[BTN_POS]) begin
				pos_q <= (pos_q == POS_HR) ? POS_SEC : pos_q + 2'd1;
			end
			if (i_press[BTN_ALARM]) begin
				alarm_en_q <= ~alarm_en_q;
			end
		end
	end

	// --------------------
	// inc button routing, nothing in clock mode
	assign inc    = i_press[BTN_INC];
	assign in_set = (mode_q == MODE_SET);

	assign sif.adv_sec   = inc && in_set && (pos_q == POS_SEC);
	assign sif.adv_min   = inc && in_set && (pos_q == POS_MIN);
	assign sif.adv_hr    = inc && in_set && (pos_q == POS_HR);
	assign sif.adv_alarm = inc && (mode_q == MODE_ALARM);

	assign sif.mode     = mode_q;
	assign sif.pos      = pos_q;
	assign sif.alarm_en = alarm_en_q;

endmodule

/* hw/button_sync.sv */
`timescale 1ns/10ps

module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sample_tick,
	input  logic [3:0] i_btn,
	output logic [3:0] o_press
);

	logic [3:0] samp_q;	// latest sample
	logic [3:0] prev_q;	// one sample older

	// buttons only looked at on the slow tick, which rides over bounce
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_q <= '0;
			prev_q <= '0;
		end else if (i_sample_tick) begin
			samp_q <= i_btn;
			prev_q <= samp_q;
		end
	end

	// sampled rising edge, one cycle wide
	assign o_press = {4{i_sample_tick}} & samp_q & ~prev_q;

endmodule

/* hw/timebase.sv */
`timescale 1ns/10ps

module timebase
	import clock_pkg::*;
#(
	parameter int p_clk_hz = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_sample_tick,
	output logic o_scan_tick,
	output logic o_beat_tick,
	output logic o_blink_on
);

	// cycles per strobe, at least one
	function automatic int div_of(input int rate);
		return (p_clk_hz / rate > 0) ? p_clk_hz / rate : 1;
	endfunction

	localparam int NUM_DIV = 5;
	localparam int CNT_W   = $clog2(p_clk_hz + 1);
	localparam int DIV [NUM_DIV] = '{
		div_of(1), div_of(SAMPLE_HZ), div_of(SCAN_HZ), div_of(BEAT_HZ), div_of(2 * BLINK_HZ)
	};

	logic [NUM_DIV-1:0] tick;	// sec, sample, scan, beat, blink
	logic               blink_q;

	for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
		logic [CNT_W-1:0] cnt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt     <= '0;
				tick[i] <= 1'b0;
			end else if (cnt == CNT_W'(DIV[i] - 1)) begin
				cnt     <= '0;
				tick[i] <= 1'b1;
			end else begin
				cnt     <= cnt + 1'b1;
				tick[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_q <= 1'b0;
		end else if (tick[4]) begin
			blink_q <= ~blink_q;
		end
	end

	assign o_sec_tick    = tick[0];
	assign o_sample_tick = tick[1];
	assign o_scan_tick   = tick[2];
	assign o_beat_tick   = tick[3];
	assign o_blink_on    = blink_q;

endmodule

/* hw/set_if.sv */
`timescale 1ns/10ps

interface set_if;

	logic [1:0] mode;
	logic [1:0] pos;
	logic       alarm_en;
	logic       adv_sec;	// single-cycle field steps
	logic       adv_min;
	logic       adv_hr;
	logic       adv_alarm;

	modport ctrl (output mode, pos, alarm_en, adv_sec, adv_min, adv_hr, adv_alarm);
	modport keeper (input mode, pos, alarm_en, adv_sec, adv_min, adv_hr, adv_alarm);
	modport disp (input mode, pos);

endinterface

/* hw/clock_pkg.sv */
package clock_pkg;

	// --------------------
	// modes and set positions
	localparam logic [1:0] MODE_CLOCK = 2'd0;
	localparam logic [1:0] MODE_SET   = 2'd1;
	localparam logic [1:0] MODE_ALARM = 2'd2;

	localparam logic [1:0] POS_SEC = 2'd0;
	localparam logic [1:0] POS_MIN = 2'd1;
	localparam logic [1:0] POS_HR  = 2'd2;

	// button order on the press vector
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	// --------------------
	localparam int FIELD_W = 6;
	localparam int SEC_MAX = 59;
	localparam int MIN_MAX = 59;
	localparam int HR_MAX  = 23;

	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;	// {a, b, c, d, e, f, g}

	localparam logic [SEG_W-1:0] SEG_DIGIT [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_1011
	};
	localparam logic [SEG_W-1:0] SEG_BLANK = '0;

	// strobe rates in Hz
	localparam int SAMPLE_HZ = 100;
	localparam int SCAN_HZ   = 1000;
	localparam int BLINK_HZ  = 4;
	localparam int BEAT_HZ   = 2;

	localparam int MELODY_LEN = 8;
	localparam int NOTE_HZ [MELODY_LEN] = '{330, 440, 523, 659, 0, 659, 587, 523};	// 0 is a rest

endpackage
